// File: cgra_dma_pkg.sv
`default_nettype none

package cgra_dma_pkg;

    // Upper bound on the stream count, sets the index width
    localparam int unsigned MAX_STREAMS = 8;

    // Byte address on the memory side
    typedef logic [31:0] addr_t;

    // Byte size or byte stride of one stream range
    typedef logic [15:0] len_t;

    // One stream word and one memory beat
    typedef logic [31:0] word_t;
    typedef logic [63:0] beat_t;

    typedef logic [$clog2(MAX_STREAMS)-1:0] stream_idx_t;

    // Range walked by one fetcher, 64 bits
    typedef struct packed {
        addr_t base;
        len_t  stride;
        len_t  size;
    } stream_cfg_t;

    // Record kept for every read still in flight
    typedef struct packed {
        stream_idx_t stream;
        // Upper half of the beat holds the word
        logic        odd_word;
    } trans_info_t;

    // Read-address channel
    typedef struct packed {
        addr_t addr;
        logic  valid;
    } rd_req_t;

    // Read-data channel, no back-pressure
    typedef struct packed {
        beat_t data;
        logic  valid;
    } rd_rsp_t;

endpackage

`default_nettype wire

// File: rr_arbiter.sv
`default_nettype none

module rr_arbiter #(
    parameter int unsigned WIDTH = 4
) (
    input  wire logic             clk_i,
    input  wire logic             rst_ni,
    input  wire logic [WIDTH-1:0] req_i,
    input  wire logic             enable_i,
    output logic      [WIDTH-1:0] grant_o
);

    // One-hot pointer, one past the last grant
    logic [WIDTH-1:0]   prio_q;
    logic [WIDTH-1:0]   prio_d;
    logic [2*WIDTH-1:0] double_req;
    logic [2*WIDTH-1:0] double_grant;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q <= WIDTH'(1);
        end else begin
            prio_q <= prio_d;
        end
    end

    always_comb begin
        // Subtracting the one-hot pointer clears the first request bit at
        // or above it, the mask then leaves only that bit
        double_req   = {req_i, req_i};
        double_grant = double_req & ~(double_req - {{WIDTH{1'b0}}, prio_q});

        // Upper copy catches requests below the pointer (wrap-around)
        if (enable_i) begin
            grant_o = double_grant[WIDTH-1:0] | double_grant[2*WIDTH-1:WIDTH];
        end else begin
            grant_o = '0;
        end

        // Rotate left past the winner, hold otherwise
        if (grant_o != '0) begin
            prio_d = (grant_o << 1) | (grant_o >> (WIDTH - 1));
        end else begin
            prio_d = prio_q;
        end
    end

endmodule

`default_nettype wire

// File: sync_fifo.sv
`default_nettype none

module sync_fifo #(
    parameter int unsigned DEPTH = 8,
    parameter type         dtype = logic [31:0]
) (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire logic                         push_i,
    input  wire dtype                         data_i,
    output logic                              full_o,
    input  wire logic                         pop_i,
    output dtype                              data_o,
    output logic                              empty_o,
    output logic [$clog2(DEPTH + 1)-1:0]      usage_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // Count reaches DEPTH itself, no wrap to zero when full
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    dtype             mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] usage_q;
    logic             do_push;
    logic             do_pop;

    // Pointer step with wrap at DEPTH, works for any depth
    function automatic logic [PTR_W-1:0] ptr_step(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // Push into a full buffer or pop from an empty one is dropped
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign full_o  = (usage_q == CNT_W'(DEPTH));
    assign empty_o = (usage_q == '0);
    assign usage_o = usage_q;
    // Head of the queue, first-word fall-through
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            usage_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_step(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_step(rd_ptr_q);
            end
            // Simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                usage_q <= usage_q + 1'b1;
            end else if (!do_push && do_pop) begin
                usage_q <= usage_q - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: stream_fetcher.sv
`default_nettype none

module stream_fetcher #(
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  wire logic                              clk_i,
    input  wire logic                              rst_ni,
    input  wire cgra_dma_pkg::stream_cfg_t         cfg_i,
    input  wire logic                              busy_i,
    input  wire logic                              clear_i,
    input  wire logic                              grant_i,
    input  wire logic                              push_i,
    input  wire logic [$clog2(FIFO_DEPTH + 1)-1:0] usage_i,
    output logic                                   req_o,
    output cgra_dma_pkg::addr_t                    addr_o,
    output logic                                   active_o
);

    import cgra_dma_pkg::*;

    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    // One bit wider than len_t so the last stride step cannot wrap
    logic [$bits(len_t):0] offset_q;
    // Words requested but not yet returned
    logic [CNT_W-1:0]      pending_q;
    // Stored plus promised words
    logic [CNT_W:0]        fill;

    // Offset walks the range, one stride per granted read
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            offset_q <= '0;
        end else if (clear_i) begin
            // End of transfer, next execute starts from the base
            offset_q <= '0;
        end else if (grant_i) begin
            offset_q <= offset_q + {1'b0, cfg_i.stride};
        end
    end

    // Up on grant, down when the beat lands in the data FIFO
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= '0;
        end else if (grant_i && !push_i) begin
            pending_q <= pending_q + 1'b1;
        end else if (!grant_i && push_i) begin
            pending_q <= pending_q - 1'b1;
        end
    end

    always_comb begin
        fill     = {1'b0, usage_i} + {1'b0, pending_q};
        // Range not yet exhausted
        active_o = (offset_q < {1'b0, cfg_i.size});
        // Only ask while every possible answer has a slot
        req_o    = active_o && busy_i && (fill < (CNT_W + 1)'(FIFO_DEPTH));
        addr_o   = cfg_i.base + addr_t'(offset_q);
    end

endmodule

`default_nettype wire

// File: read_engine.sv
`default_nettype none

module read_engine #(
    parameter int unsigned NUM_STREAMS     = 4,
    parameter int unsigned MAX_OUTSTANDING = 8
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire logic                   execute_i,
    input  wire logic [NUM_STREAMS-1:0] active_i,
    input  wire logic [NUM_STREAMS-1:0] grant_i,
    input  wire cgra_dma_pkg::addr_t    addr_i [NUM_STREAMS],
    output cgra_dma_pkg::rd_req_t       rd_req_o,
    input  wire logic                   rd_ready_i,
    input  wire cgra_dma_pkg::rd_rsp_t  rd_rsp_i,
    output logic                        busy_o,
    output logic                        clear_o,
    output logic                        done_o,
    output logic                        arb_enable_o,
    output logic [NUM_STREAMS-1:0]      push_o,
    output cgra_dma_pkg::word_t         word_o
);

    import cgra_dma_pkg::*;

    localparam int unsigned OUTST_W = $clog2(MAX_OUTSTANDING + 1);

    // Transfer flag
    logic busy_q;
    logic busy_d;

    // Read-address register
    logic  req_valid_q;
    addr_t req_addr_q;

    // Granted stream
    addr_t       sel_addr;
    stream_idx_t sel_idx;
    logic        new_grant;

    // Outstanding record FIFO
    trans_info_t        outst_in;
    trans_info_t        outst_out;
    logic               outst_push;
    logic               outst_pop;
    logic               outst_full;
    logic               outst_empty;
    logic [OUTST_W-1:0] outst_usage;
    // Empty now or after this cycle's last beat
    logic               outst_drained;

    always_comb begin
        outst_drained = outst_empty ||
                        (outst_usage == OUTST_W'(1) && outst_pop && !outst_push);
        busy_d = busy_q;
        if (execute_i) begin
            busy_d = 1'b1;
        end else if (active_i == '0 && outst_drained) begin
            busy_d = 1'b0;
        end
        // One-cycle pulse on the falling edge of the flag
        clear_o = busy_q && !busy_d;
        busy_o  = busy_q;
        done_o  = !busy_q;
    end

    // Grant one-hot to index and address, OR-mux without priority
    always_comb begin
        sel_addr = '0;
        sel_idx  = '0;
        for (int i = 0; i < NUM_STREAMS; i++) begin
            if (grant_i[i]) begin
                sel_addr = sel_addr | addr_i[i];
                sel_idx  = sel_idx | stream_idx_t'(i);
            end
        end
        new_grant = (grant_i != '0);
    end

    // Bus free when idle or the current request is taken this cycle
    assign arb_enable_o = (!req_valid_q || rd_ready_i) && !outst_full;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q      <= 1'b0;
            req_valid_q <= 1'b0;
        end else begin
            busy_q <= busy_d;
            if (new_grant) begin
                req_valid_q <= 1'b1;
            end else if (rd_ready_i) begin
                req_valid_q <= 1'b0;
            end
        end
    end

    // Address only loads on a grant, so it holds while ready is low
    always_ff @(posedge clk_i) begin
        if (new_grant) begin
            req_addr_q <= {sel_addr[31:3], 3'b000};
        end
    end

    assign rd_req_o = '{addr: req_addr_q, valid: req_valid_q};

    // Record taken at grant time, so an unsent request counts as in flight
    assign outst_in   = '{stream: sel_idx, odd_word: sel_addr[2]};
    assign outst_push = new_grant;
    // Beats return in order, head record belongs to the current beat
    assign outst_pop  = rd_rsp_i.valid;

    always_comb begin
        word_o = outst_out.odd_word ? rd_rsp_i.data[63:32] : rd_rsp_i.data[31:0];
        for (int i = 0; i < NUM_STREAMS; i++) begin
            push_o[i] = rd_rsp_i.valid && (outst_out.stream == stream_idx_t'(i));
        end
    end

    sync_fifo #(
        .DEPTH (MAX_OUTSTANDING),
        .dtype (trans_info_t)
    ) i_outst_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (outst_push),
        .data_i  (outst_in),
        .full_o  (outst_full),
        .pop_i   (outst_pop),
        .data_o  (outst_out),
        .empty_o (outst_empty),
        .usage_o (outst_usage)
    );

endmodule

`default_nettype wire

// File: cgra_input_dma.sv
`default_nettype none

module cgra_input_dma #(
    parameter int unsigned NUM_STREAMS     = 4,
    parameter int unsigned FIFO_DEPTH      = 8,
    parameter int unsigned MAX_OUTSTANDING = 8
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      execute_i,
    input  wire cgra_dma_pkg::stream_cfg_t cfg_i [NUM_STREAMS],
    output logic                           done_o,
    // Memory read port
    output cgra_dma_pkg::rd_req_t          rd_req_o,
    input  wire logic                      rd_ready_i,
    input  wire cgra_dma_pkg::rd_rsp_t     rd_rsp_i,
    // CGRA input streams
    output cgra_dma_pkg::word_t            stream_data_o [NUM_STREAMS],
    output logic [NUM_STREAMS-1:0]         stream_valid_o,
    input  wire logic [NUM_STREAMS-1:0]    stream_ready_i
);

    import cgra_dma_pkg::*;

    localparam int unsigned USAGE_W = $clog2(FIFO_DEPTH + 1);

    // Fetcher to arbiter and engine
    logic [NUM_STREAMS-1:0] arb_req;
    logic [NUM_STREAMS-1:0] arb_grant;
    logic [NUM_STREAMS-1:0] active;
    addr_t                  fetch_addr [NUM_STREAMS];

    // Engine control
    logic arb_enable;
    logic busy;
    logic clear;

    // Read data into the stream FIFOs
    logic [NUM_STREAMS-1:0] push;
    word_t                  word;
    logic [USAGE_W-1:0]     usage [NUM_STREAMS];
    logic [NUM_STREAMS-1:0] fifo_empty;
    logic [NUM_STREAMS-1:0] fifo_pop;

    // Sink handshake
    assign stream_valid_o = ~fifo_empty;
    assign fifo_pop       = stream_valid_o & stream_ready_i;

    for (genvar i = 0; i < NUM_STREAMS; i++) begin : g_stream
        stream_fetcher #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) i_fetcher (
            .clk_i    (clk_i),
            .rst_ni   (rst_ni),
            .cfg_i    (cfg_i[i]),
            .busy_i   (busy),
            .clear_i  (clear),
            .grant_i  (arb_grant[i]),
            .push_i   (push[i]),
            .usage_i  (usage[i]),
            .req_o    (arb_req[i]),
            .addr_o   (fetch_addr[i]),
            .active_o (active[i])
        );

        // Overflow ruled out by the fetcher's pending count
        sync_fifo #(
            .DEPTH (FIFO_DEPTH),
            .dtype (word_t)
        ) i_data_fifo (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .push_i  (push[i]),
            .data_i  (word),
            .full_o  (),
            .pop_i   (fifo_pop[i]),
            .data_o  (stream_data_o[i]),
            .empty_o (fifo_empty[i]),
            .usage_o (usage[i])
        );
    end

    rr_arbiter #(
        .WIDTH (NUM_STREAMS)
    ) i_arbiter (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (arb_req),
        .enable_i (arb_enable),
        .grant_o  (arb_grant)
    );

    read_engine #(
        .NUM_STREAMS     (NUM_STREAMS),
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) i_engine (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .execute_i    (execute_i),
        .active_i     (active),
        .grant_i      (arb_grant),
        .addr_i       (fetch_addr),
        .rd_req_o     (rd_req_o),
        .rd_ready_i   (rd_ready_i),
        .rd_rsp_i     (rd_rsp_i),
        .busy_o       (busy),
        .clear_o      (clear),
        .done_o       (done_o),
        .arb_enable_o (arb_enable),
        .push_o       (push),
        .word_o       (word)
    );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`default_nettype none

module tb_mem_model #(
    parameter int unsigned MAX_DELAY = 5
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire cgra_dma_pkg::rd_req_t rd_req_i,
    output logic                       rd_ready_o,
    output cgra_dma_pkg::rd_rsp_t      rd_rsp_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import cgra_dma_pkg::*;

    integer      seed = 15;
    int unsigned cycle;
    int unsigned due;
    int unsigned last_due;
    addr_t       beat_addr;
    // Accepted addresses and the cycle each answer is due, in request order
    addr_t       addr_q [$];
    int unsigned due_q [$];

    // Word stored at byte address a
    function automatic word_t mem_word(input addr_t a);
        return {a[31:16], ~a[15:0]};
    endfunction

    initial begin
        rd_ready_o = 1'b0;
        rd_rsp_o   = '0;
        cycle      = 0;
        last_due   = 0;
        forever begin
            // Handshake sampled mid-cycle, both sides stable
            @(negedge clk_i);
            if (!rst_ni) begin
                addr_q.delete();
                due_q.delete();
            end else if (rd_req_i.valid && rd_ready_o) begin
                due = cycle + 1 + ({$random(seed)} % (MAX_DELAY + 1));
                // Never overtake an earlier answer
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                addr_q.push_back(rd_req_i.addr);
                due_q.push_back(due);
            end
            @(posedge clk_i);
            #10;
            cycle++;
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                beat_addr = addr_q.pop_front();
                due       = due_q.pop_front();
                rd_rsp_o  = '{data: {mem_word(beat_addr + 32'd4), mem_word(beat_addr)},
                              valid: 1'b1};
            end else begin
                rd_rsp_o = '0;
            end
            // Ready low about one cycle in four
            rd_ready_o = rst_ni && (({$random(seed)} % 4) != 0);
        end
    end

endmodule

`default_nettype wire

// File: tb_cgra_input_dma.sv
`default_nettype none

module tb_cgra_input_dma;

    timeunit 1ns;
    timeprecision 1ps;

    import cgra_dma_pkg::*;

    localparam int unsigned NUM_STREAMS = 4;
    localparam int unsigned MAX_TESTS   = 32;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   execute_i;
    stream_cfg_t            cfg [NUM_STREAMS];
    logic                   done_o;
    rd_req_t                rd_req_o;
    logic                   rd_ready_i;
    rd_rsp_t                rd_rsp_i;
    word_t                  stream_data_o [NUM_STREAMS];
    logic [NUM_STREAMS-1:0] stream_valid_o;
    logic [NUM_STREAMS-1:0] stream_ready_i;

    // Cases loaded from the data file
    stream_cfg_t            case_cfg [MAX_TESTS][NUM_STREAMS];
    int unsigned            case_stall [MAX_TESTS];
    logic [NUM_STREAMS-1:0] case_mask [MAX_TESTS];
    int unsigned            case_total [MAX_TESTS];
    int unsigned            num_tests;
    int unsigned            limit_cycles;

    // Scoreboard of the running test
    int unsigned            exp_cnt [NUM_STREAMS];
    int unsigned            got_cnt [NUM_STREAMS];
    int unsigned            accepted;
    int unsigned            beats;
    int unsigned            stall_pct;
    logic [NUM_STREAMS-1:0] stall_mask;
    logic                   req_waiting;
    addr_t                  held_addr;

    int unsigned            errors;
    int unsigned            checks;
    integer                 seed = 15;

    cgra_input_dma #(
        .NUM_STREAMS     (NUM_STREAMS),
        .FIFO_DEPTH      (8),
        .MAX_OUTSTANDING (8)
    ) cgra_input_dma_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .execute_i      (execute_i),
        .cfg_i          (cfg),
        .done_o         (done_o),
        .rd_req_o       (rd_req_o),
        .rd_ready_i     (rd_ready_i),
        .rd_rsp_i       (rd_rsp_i),
        .stream_data_o  (stream_data_o),
        .stream_valid_o (stream_valid_o),
        .stream_ready_i (stream_ready_i)
    );

    tb_mem_model mem_model_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rd_req_i   (rd_req_o),
        .rd_ready_o (rd_ready_i),
        .rd_rsp_o   (rd_rsp_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Word k of a stream is the memory word at its address rounded down to 4
    function automatic word_t expected_word(input stream_cfg_t c, input int unsigned k);
        addr_t a;
        a      = c.base + addr_t'(k) * addr_t'(c.stride);
        a[1:0] = 2'b00;
        return {a[31:16], ~a[15:0]};
    endfunction

    // Number of offsets below the size equals ceil(size / stride)
    function automatic int unsigned word_count(input stream_cfg_t c);
        int unsigned n;
        n = 0;
        while (c.stride != 0 && n * c.stride < c.size) begin
            n++;
        end
        return n;
    endfunction

    function automatic logic request_in_range(input addr_t a);
        logic  hit;
        addr_t w;
        hit = 1'b0;
        for (int s = 0; s < NUM_STREAMS; s++) begin
            for (int unsigned k = 0; k < exp_cnt[s]; k++) begin
                w = cfg[s].base + addr_t'(k) * addr_t'(cfg[s].stride);
                if ({w[31:3], 3'b000} == a) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    function automatic logic all_received();
        logic ok;
        ok = 1'b1;
        for (int s = 0; s < NUM_STREAMS; s++) begin
            if (got_cnt[s] < exp_cnt[s]) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("ERR %0t ns %s expected %0h got %0h", $time, sig, exp, act);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("%0t ns: %s", $time, what);
        errors++;
    endtask

    // Sinks pick a new ready 10 ns after the edge
    task automatic next_cycle();
        @(posedge clk_i);
        #10;
        for (int s = 0; s < NUM_STREAMS; s++) begin
            stream_ready_i[s] = !(stall_mask[s] && (({$random(seed)} % 100) < stall_pct));
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] v [15];
        fd        = $fopen("dma_cases.txt", "r");
        num_tests = 0;
        if (fd == 0) begin
            report_failure("cannot open dma_cases.txt");
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = "";
            n    = $fgets(line, fd);
            // Comment and blank lines skipped
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %d %h %d",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                            v[8], v[9], v[10], v[11], v[12], v[13], v[14]);
                if (n != 15) begin
                    report_failure($sformatf("malformed case line: %s", line));
                end else begin
                    for (int s = 0; s < NUM_STREAMS; s++) begin
                        case_cfg[num_tests][s] = '{base: v[3*s], stride: len_t'(v[3*s+1]),
                                                   size: len_t'(v[3*s+2])};
                    end
                    case_stall[num_tests] = v[12];
                    case_mask[num_tests]  = v[13][NUM_STREAMS-1:0];
                    case_total[num_tests] = v[14];
                    num_tests++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int unsigned t);
        int unsigned errs_before;
        int unsigned total;
        errs_before = errors;
        total       = 0;
        stall_pct   = case_stall[t];
        stall_mask  = case_mask[t];
        accepted    = 0;
        beats       = 0;
        for (int s = 0; s < NUM_STREAMS; s++) begin
            cfg[s]     = case_cfg[t][s];
            exp_cnt[s] = word_count(cfg[s]);
            got_cnt[s] = 0;
            total      = total + exp_cnt[s];
        end
        execute_i = 1'b1;
        next_cycle();
        execute_i = 1'b0;
        checks++;
        assert (done_o == 1'b0) else report_mismatch("done_o", 64'd0, done_o);
        while (!done_o) begin
            next_cycle();
        end
        // Every read issued and answered by the time done returns
        checks += 2;
        assert (accepted == total) else report_mismatch("accepted requests", total, accepted);
        assert (beats == total) else report_mismatch("returned beats", total, beats);
        // Stalled sinks may still hold words
        while (!all_received()) begin
            next_cycle();
        end
        repeat (8) next_cycle();
        for (int s = 0; s < NUM_STREAMS; s++) begin
            checks++;
            assert (got_cnt[s] == exp_cnt[s])
                else report_mismatch($sformatf("word count stream %0d", s), exp_cnt[s], got_cnt[s]);
        end
        $display("test %0d: %0d words, stall %0d%% on sinks %b, %0d errors",
                 t, total, stall_pct, stall_mask, errors - errs_before);
    endtask

    // Request channel, returned beats and sink words are all sampled mid-cycle
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (req_waiting) begin
                checks++;
                assert (rd_req_o.valid) else report_failure("rd_req_o.valid dropped before ready");
                assert (rd_req_o.addr == held_addr)
                    else report_mismatch("rd_req_o.addr", held_addr, rd_req_o.addr);
            end
            if (rd_req_o.valid) begin
                checks++;
                assert (rd_req_o.addr[2:0] == 3'b000)
                    else report_failure("read address not aligned to 8 bytes");
                assert (request_in_range(rd_req_o.addr))
                    else report_failure("read address outside every stream range");
                if (rd_ready_i) begin
                    accepted++;
                end
            end
            req_waiting = rd_req_o.valid && !rd_ready_i;
            held_addr   = rd_req_o.addr;
            if (rd_rsp_i.valid) begin
                beats++;
            end
            for (int s = 0; s < NUM_STREAMS; s++) begin
                if (stream_valid_o[s] && stream_ready_i[s]) begin
                    checks++;
                    assert (got_cnt[s] < exp_cnt[s])
                        else report_failure($sformatf("stream %0d delivered more than %0d words",
                                                      s, exp_cnt[s]));
                    if (got_cnt[s] < exp_cnt[s]) begin
                        assert (stream_data_o[s] == expected_word(cfg[s], got_cnt[s]))
                            else report_mismatch($sformatf("stream_data_o[%0d]", s),
                                                 expected_word(cfg[s], got_cnt[s]),
                                                 stream_data_o[s]);
                    end
                    got_cnt[s]++;
                end
            end
        end
    end

    // Watchdog allows 40 cycles per expected word plus a fixed margin
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles, a transfer never finished", limit_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int unsigned limit;
        int unsigned sum;
        rst_ni         = 1'b0;
        execute_i      = 1'b0;
        stream_ready_i = '0;
        stall_pct      = 0;
        stall_mask     = '0;
        errors         = 0;
        checks         = 0;
        accepted       = 0;
        beats          = 0;
        req_waiting    = 1'b0;
        held_addr      = '0;
        for (int s = 0; s < NUM_STREAMS; s++) begin
            cfg[s]     = '0;
            exp_cnt[s] = 0;
            got_cnt[s] = 0;
        end
        load_cases();
        limit = 200;
        for (int unsigned t = 0; t < num_tests; t++) begin
            sum = 0;
            for (int s = 0; s < NUM_STREAMS; s++) begin
                sum = sum + word_count(case_cfg[t][s]);
            end
            // File total cross-checks the ranges
            checks++;
            assert (sum == case_total[t])
                else report_mismatch($sformatf("word total of case %0d", t), case_total[t], sum);
            limit = limit + 40 * sum;
        end
        limit_cycles = limit;

        repeat (4) @(posedge clk_i);
        #10;
        rst_ni = 1'b1;
        next_cycle();
        checks++;
        assert (done_o == 1'b1) else report_mismatch("done_o", 64'd1, done_o);
        assert (rd_req_o.valid == 1'b0)
            else report_mismatch("rd_req_o.valid", 64'd0, rd_req_o.valid);
        assert (stream_valid_o == '0) else report_mismatch("stream_valid_o", 64'd0, stream_valid_o);

        for (int unsigned t = 0; t < num_tests; t++) begin
            run_test(t);
        end

        $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
cgra_dma_pkg.sv
rr_arbiter.sv
sync_fifo.sv
stream_fetcher.sv
read_engine.sv
cgra_input_dma.sv
tb_mem_model.sv
tb_cgra_input_dma.sv

// File: Bender.yml
package:
  name: cgra_input_dma

sources:
  - cgra_dma_pkg.sv
  - rr_arbiter.sv
  - sync_fifo.sv
  - stream_fetcher.sv
  - read_engine.sv
  - cgra_input_dma.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_cgra_input_dma.sv

// File: dma_cases.txt
# Per stream 0..3: base stride size (hex), then stall percent (dec), stalled sinks mask (hex),
# total expected words over all streams (dec)
00001000 0004 0040 00002000 0004 0040 00003000 0004 0040 00004000 0004 0040 0 0 64
00001000 0004 0040 00002000 0004 0040 00003000 0004 0040 00004000 0004 0040 0 0 64
00010004 0008 0040 00020000 000c 0060 00030008 0010 0080 00040004 0014 00a0 20 f 32
00005001 0003 0030 00006002 0005 0032 00007003 0007 0023 00008000 0004 0010 0 0 35
00001000 0004 0020 00002000 0004 0020 00003000 0004 0000 00004000 0004 0020 0 0 24
00009000 0004 0040 0000a000 0004 0040 0000b000 0008 0040 0000c000 0004 0040 90 2 56
00001000 0004 0000 00002000 0004 0000 00003000 0008 0000 00004000 0004 0000 0 0 0
ffff0000 0100 1000 80000000 8000 ffff 00000000 0004 0001 7ffffffc 0008 0021 50 f 24
0000d000 0004 0080 0000e000 0004 0080 0000f000 0004 0080 00010000 0004 0080 30 f 128
00012340 0004 0100 00000000 0004 0000 00000000 0004 0000 00000000 0004 0000 0 0 64
00020000 0004 0040 00021004 0008 0040 00022000 0004 0040 00023004 0008 0080 90 8 56
